/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP = tb_cache_set
FILELIST = sources.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

# build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/cache_maint_pkg.sv */
// maintenance opcodes, request struct and tag word union
`default_nettype none

package cache_maint_pkg;

   parameter int MAINT_WORD_W = 32;
   parameter int MAINT_IDX_W = 6;
   // unused upper bits of the tag word
   parameter int MAINT_PAD_W = MAINT_WORD_W - ($bits(cache_set_pkg::tagsec_t) +
                                               cache_set_pkg::STATE_W + 2);

   typedef enum logic [3:0] {
      op_read = 4'b1100,
      op_write = 4'b1110
   } maint_op_e;

   typedef struct packed {
      maint_op_e op;
      logic [cache_set_pkg::WAY_W-1:0] way;
      logic [MAINT_IDX_W-1:0] word;
   } maint_req_t;

   // word 0 layout, err in bit 0
   typedef struct packed {
      logic [MAINT_PAD_W-1:0] pad;
      cache_set_pkg::tagsec_t tagsec;
      logic [cache_set_pkg::STATE_W-1:0] state;
      logic nru;
      logic err;
   } maint_fields_t;

   typedef union packed {
      logic [MAINT_WORD_W-1:0] raw;
      maint_fields_t fields;
   } maint_word_u;

endpackage

`default_nettype wire

/* source/cache_set_pkg.sv */
// cache set geometry, address fields, lookup and fill structs, lookup class enum
`default_nettype none

package cache_set_pkg;

   // address geometry
   parameter int ADDRESS_W = 32;
   parameter int LINE_OFFSET_W = 6;
   parameter int SET_W = 9;
   parameter int BANK_W = 1;
   parameter int TAG_W = ADDRESS_W - BANK_W - SET_W - LINE_OFFSET_W;

   // way pointers are sized for up to four ways
   parameter int WAY_W = 2;
   parameter int STATE_W = 2;
   parameter int FILL_ID_W = 6;
   parameter int BEAT_DATA_W = 64;

   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [BANK_W-1:0] bank;
      logic [SET_W-1:0] set;
      logic [LINE_OFFSET_W-1:0] offset;
   } addr_fields_t;

   // security bit sits above the address tag
   typedef struct packed {
      logic security;
      logic [TAG_W-1:0] tag;
   } tagsec_t;

   typedef struct packed {
      addr_fields_t addr;
      logic security;
      logic allocate;
      logic tag_state_update;
      logic [STATE_W-1:0] new_state;
      logic nack;
   } lookup_req_t;

   typedef enum logic [2:0] {
      class_true_miss = 3'd0,
      class_true_hit = 3'd1,
      class_true_hit_upgrade = 3'd2,
      class_false_miss = 3'd3,
      class_false_miss_special = 3'd4,
      class_false_hit = 3'd5
   } lookup_class_e;

   typedef struct packed {
      addr_fields_t addr;
      logic security;
      logic [WAY_W-1:0] way;
      logic [STATE_W-1:0] state;
   } fill_cmd_t;

   typedef struct packed {
      logic [BEAT_DATA_W-1:0] data;
      logic [WAY_W-1:0] way;
      logic [FILL_ID_W-1:0] id;
   } fill_beat_t;

endpackage

`default_nettype wire

/* source/cache_set_top.sv */
// cache set top level connecting lookup, fill tracking and tag storage
`default_nettype none
`timescale 1ns/100ps

module cache_set_top
   import cache_set_pkg::*;
   import cache_maint_pkg::*;
#(
   parameter int unsigned N_WAYS = 2,
   parameter int unsigned BURST_BEATS = 4,
   parameter int unsigned SET_INDEX = 0,
   parameter int unsigned BANK_INDEX = 0
) (
   input wire clk,
   input wire reset_n,
   input wire lookup_valid,
   output logic lookup_ready,
   input wire lookup_req_t lookup_req,
   output logic result_valid,
   input wire result_ready,
   output lookup_class_e result_class,
   output logic [N_WAYS-1:0] hit_way_vec,
   output logic [STATE_W-1:0] current_state,
   output logic [N_WAYS-1:0] busy_vec,
   output logic [N_WAYS-1:0] stale_vec,
   output logic nack_no_allocate,
   input wire fill_valid,
   output logic fill_ready,
   input wire fill_cmd_t fill_cmd,
   input wire beat_valid,
   output logic beat_ready,
   input wire fill_beat_t fill_beat,
   input wire done_valid,
   input wire [FILL_ID_W-1:0] done_id,
   input wire maint_valid,
   output logic maint_ready,
   input wire maint_req_t maint_req,
   input wire maint_word_u maint_wdata,
   output maint_word_u maint_rdata,
   output logic maint_rvalid
);

   logic fill_fire;
   logic beat_fire;
   logic maint_fire;
   logic last_beat;
   logic fill_start;
   logic [WAY_W-1:0] start_way;
   tagsec_t start_tag;
   logic start_hit;
   logic upd_valid;
   logic [WAY_W-1:0] upd_way;
   logic [STATE_W-1:0] upd_state;
   logic [N_WAYS-1:0] state_pending;
   logic [N_WAYS-1:0] busy;
   tagsec_t [N_WAYS-1:0] tags;
   logic [N_WAYS-1:0][STATE_W-1:0] states;
   tagsec_t [N_WAYS-1:0] shadow_tags;
   logic [N_WAYS-1:0] despite_hit;

   // fill, beat and maintenance channels never stall
   assign fill_ready = 1'b1;
   assign beat_ready = 1'b1;
   assign maint_ready = 1'b1;
   assign fill_fire = fill_valid && fill_ready;
   assign beat_fire = beat_valid && beat_ready;
   assign maint_fire = maint_valid && maint_ready;

   lookup_classifier #(
      .N_WAYS(N_WAYS), .SET_INDEX(SET_INDEX), .BANK_INDEX(BANK_INDEX)
   ) i_lookup_classifier (
      .clk(clk), .reset_n(reset_n), .lookup_valid(lookup_valid),
      .lookup_req(lookup_req), .result_ready(result_ready), .tags(tags),
      .states(states), .shadow_tags(shadow_tags), .despite_hit(despite_hit),
      .busy(busy), .state_pending(state_pending), .lookup_ready(lookup_ready),
      .result_valid(result_valid), .result_class(result_class),
      .hit_way_vec(hit_way_vec), .current_state(current_state), .busy_vec(busy_vec),
      .stale_vec(stale_vec), .nack_no_allocate(nack_no_allocate),
      .fill_start(fill_start), .start_way(start_way), .start_tag(start_tag),
      .start_hit(start_hit), .upd_valid(upd_valid), .upd_way(upd_way),
      .upd_state(upd_state)
   );

   fill_tracker #(
      .N_WAYS(N_WAYS), .SET_INDEX(SET_INDEX), .BANK_INDEX(BANK_INDEX)
   ) i_fill_tracker (
      .clk(clk), .reset_n(reset_n), .fill_start(fill_start), .start_way(start_way),
      .fill_fire(fill_fire), .fill_way(fill_cmd.way), .fill_addr(fill_cmd.addr),
      .last_beat(last_beat), .beat_way(fill_beat.way), .beat_id(fill_beat.id),
      .done_valid(done_valid), .done_id(done_id), .state_pending(state_pending),
      .data_pending(), .busy(busy)
   );

   fill_beat_counter #(
      .BURST_BEATS(BURST_BEATS)
   ) i_fill_beat_counter (
      .clk(clk), .reset_n(reset_n), .beat_fire(beat_fire), .last_beat(last_beat)
   );

   tag_state_array #(
      .N_WAYS(N_WAYS), .SET_INDEX(SET_INDEX), .BANK_INDEX(BANK_INDEX)
   ) i_tag_state_array (
      .clk(clk), .reset_n(reset_n), .fill_start(fill_start), .start_way(start_way),
      .start_tag(start_tag), .start_hit(start_hit), .upd_valid(upd_valid),
      .upd_way(upd_way), .upd_state(upd_state), .fill_fire(fill_fire),
      .fill_cmd(fill_cmd), .busy(busy), .state_pending(state_pending),
      .maint_fire(maint_fire), .maint_req(maint_req), .maint_wdata(maint_wdata),
      .tags(tags), .states(states), .shadow_tags(shadow_tags),
      .despite_hit(despite_hit), .maint_rdata(maint_rdata), .maint_rvalid(maint_rvalid)
   );

endmodule

`default_nettype wire

/* source/fill_beat_counter.sv */
// fill data beat counter with last beat flag
`default_nettype none
`timescale 1ns/100ps

module fill_beat_counter #(
   parameter int unsigned BURST_BEATS = 4
) (
   input wire clk,
   input wire reset_n,
   input wire beat_fire,
   output logic last_beat
);

   localparam int CNT_W = (BURST_BEATS > 1) ? $clog2(BURST_BEATS) : 1;

   logic [CNT_W-1:0] count;
   logic at_end;

   assign at_end = (count == CNT_W'(BURST_BEATS - 1));

   // only an accepted beat can be the last one
   assign last_beat = beat_fire && at_end;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         count <= '0;
      end else if (beat_fire) begin
         // wrap back for the next burst
         if (at_end) begin
            count <= '0;
         end else begin
            count <= count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* source/fill_tracker.sv */
// per-way fill tracker with state, data and done pending phases
`default_nettype none
`timescale 1ns/100ps

module fill_tracker
   import cache_set_pkg::*;
#(
   parameter int unsigned N_WAYS = 2,
   parameter int unsigned SET_INDEX = 0,
   parameter int unsigned BANK_INDEX = 0
) (
   input wire clk,
   input wire reset_n,
   input wire fill_start,
   input wire [WAY_W-1:0] start_way,
   input wire fill_fire,
   input wire [WAY_W-1:0] fill_way,
   input wire addr_fields_t fill_addr,
   input wire last_beat,
   input wire [WAY_W-1:0] beat_way,
   input wire [FILL_ID_W-1:0] beat_id,
   input wire done_valid,
   input wire [FILL_ID_W-1:0] done_id,
   output logic [N_WAYS-1:0] state_pending,
   output logic [N_WAYS-1:0] data_pending,
   output logic [N_WAYS-1:0] busy
);

   logic [N_WAYS-1:0] done_pending;
   logic [N_WAYS-1:0][FILL_ID_W-1:0] fill_id;
   logic fill_here;
   logic [N_WAYS-1:0] start_vec;
   logic [N_WAYS-1:0] state_clr_vec;
   logic [N_WAYS-1:0] data_clr_vec;
   logic [N_WAYS-1:0] done_clr_vec;

   assign fill_here = fill_fire &&
                      (fill_addr.set == SET_W'(SET_INDEX)) &&
                      (fill_addr.bank == BANK_W'(BANK_INDEX));

   // one-hot set and clear vectors, only pending phases can clear
   assign start_vec = N_WAYS'(fill_start) << start_way;
   assign state_clr_vec = (N_WAYS'(fill_here) << fill_way) & state_pending;
   assign data_clr_vec = (N_WAYS'(last_beat) << beat_way) & data_pending;

   // a done only retires the way whose stored fill id matches
   always_comb begin
      for (int i = 0; i < N_WAYS; i++) begin
         done_clr_vec[i] = done_valid && done_pending[i] && (fill_id[i] == done_id);
      end
   end

   // idle -> state+data pending -> done pending -> idle, per way
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state_pending <= '0;
         data_pending <= '0;
         done_pending <= '0;
      end else begin
         state_pending <= (state_pending & ~state_clr_vec) | start_vec;
         data_pending <= (data_pending & ~data_clr_vec) | start_vec;
         done_pending <= (done_pending & ~done_clr_vec) | data_clr_vec;
      end
   end

   // fill id is captured with the last data beat
   always_ff @(posedge clk) begin
      for (int i = 0; i < N_WAYS; i++) begin
         if (data_clr_vec[i]) begin
            fill_id[i] <= beat_id;
         end
      end
   end

   assign busy = state_pending | data_pending | done_pending;

endmodule

`default_nettype wire

/* source/lookup_classifier.sv */
// lookup hit vectors, class decode, way allocation and result register
`default_nettype none
`timescale 1ns/100ps

module lookup_classifier
   import cache_set_pkg::*;
#(
   parameter int unsigned N_WAYS = 2,
   parameter int unsigned SET_INDEX = 0,
   parameter int unsigned BANK_INDEX = 0
) (
   input wire clk,
   input wire reset_n,
   input wire lookup_valid,
   input wire lookup_req_t lookup_req,
   input wire result_ready,
   input wire tagsec_t [N_WAYS-1:0] tags,
   input wire [N_WAYS-1:0][STATE_W-1:0] states,
   input wire tagsec_t [N_WAYS-1:0] shadow_tags,
   input wire [N_WAYS-1:0] despite_hit,
   input wire [N_WAYS-1:0] busy,
   input wire [N_WAYS-1:0] state_pending,
   output logic lookup_ready,
   output logic result_valid,
   output lookup_class_e result_class,
   output logic [N_WAYS-1:0] hit_way_vec,
   output logic [STATE_W-1:0] current_state,
   output logic [N_WAYS-1:0] busy_vec,
   output logic [N_WAYS-1:0] stale_vec,
   output logic nack_no_allocate,
   output logic fill_start,
   output logic [WAY_W-1:0] start_way,
   output tagsec_t start_tag,
   output logic start_hit,
   output logic upd_valid,
   output logic [WAY_W-1:0] upd_way,
   output logic [STATE_W-1:0] upd_state
);

   logic lookup_fire;
   logic in_set;
   logic all_busy;
   logic true_hit;
   logic upgrade;
   logic [N_WAYS-1:0] tag_hit;
   logic [N_WAYS-1:0] shadow_hit;
   logic [N_WAYS-1:0] true_miss_vec;
   logic [N_WAYS-1:0] true_hit_vec;
   logic [N_WAYS-1:0] upgrade_vec;
   logic [N_WAYS-1:0] false_miss_vec;
   logic [N_WAYS-1:0] special_vec;
   logic [N_WAYS-1:0] rest_vec;
   logic [N_WAYS-1:0] start_vec;
   logic [WAY_W-1:0] hit_way;
   logic [WAY_W-1:0] alloc_way;
   logic [WAY_W-1:0] final_way;
   logic [STATE_W-1:0] hit_state;
   lookup_class_e lk_class;

   assign lookup_ready = result_ready || !result_valid;
   assign lookup_fire = lookup_valid && lookup_ready;
   assign in_set = (lookup_req.addr.set == SET_W'(SET_INDEX)) &&
                   (lookup_req.addr.bank == BANK_W'(BANK_INDEX));
   assign start_tag = '{security: lookup_req.security, tag: lookup_req.addr.tag};
   assign all_busy = in_set && (&busy);

   // shadow tags are live only while their way is busy
   always_comb begin
      for (int i = 0; i < N_WAYS; i++) begin
         tag_hit[i] = in_set && (tags[i] == start_tag) && (states[i] != '0);
         shadow_hit[i] = in_set && (shadow_tags[i] == start_tag) && busy[i];
      end
   end

   assign true_miss_vec = ~tag_hit & ~shadow_hit;
   assign true_hit_vec = tag_hit & ~busy;
   assign upgrade_vec = tag_hit & shadow_hit & despite_hit;
   assign false_miss_vec = (~tag_hit & shadow_hit & ~despite_hit) |
                           (tag_hit & shadow_hit & ~state_pending & ~despite_hit);
   assign special_vec = ~tag_hit & shadow_hit & despite_hit;
   // ways that neither hit nor block a class: false hits and true misses
   assign rest_vec = (tag_hit & busy & ~shadow_hit & ~despite_hit) | true_miss_vec;

   assign true_hit = |true_hit_vec && ((rest_vec | true_hit_vec) == '1);
   assign upgrade = |upgrade_vec && ((rest_vec | upgrade_vec) == '1);

   always_comb begin
      if (&true_miss_vec) lk_class = class_true_miss;
      else if (true_hit) lk_class = class_true_hit;
      else if (upgrade) lk_class = class_true_hit_upgrade;
      else if (|false_miss_vec && ((rest_vec | false_miss_vec) == '1))
         lk_class = class_false_miss;
      else if (|special_vec && ((rest_vec | special_vec) == '1))
         lk_class = class_false_miss_special;
      else lk_class = class_false_hit;
   end

   // lowest idle invalid way, else lowest idle way
   always_comb begin
      alloc_way = '0;
      hit_way = '0;
      hit_state = '0;
      for (int i = N_WAYS - 1; i >= 0; i--) begin
         if (!busy[i]) alloc_way = WAY_W'(i);
      end
      for (int i = N_WAYS - 1; i >= 0; i--) begin
         if (!busy[i] && (states[i] == '0)) alloc_way = WAY_W'(i);
      end
      for (int i = 0; i < N_WAYS; i++) begin
         if (true_hit_vec[i] || upgrade_vec[i]) begin
            hit_way = WAY_W'(i);
            hit_state = states[i];
         end
      end
   end

   assign final_way = (true_hit || upgrade) ? hit_way : alloc_way;
   assign fill_start = lookup_fire && in_set && lookup_req.allocate && !lookup_req.nack &&
                       !all_busy && (true_hit || (lk_class == class_true_miss));
   assign start_way = final_way;
   assign start_hit = true_hit;
   assign start_vec = N_WAYS'(fill_start) << final_way;

   assign upd_valid = lookup_fire && in_set && lookup_req.tag_state_update &&
                      !lookup_req.nack && (true_hit || upgrade ||
                      ((lk_class == class_true_miss) && lookup_req.allocate && !all_busy));
   assign upd_way = final_way;
   assign upd_state = lookup_req.new_state;

   // result holds while the consumer stalls
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) result_valid <= 1'b0;
      else if (lookup_fire) result_valid <= 1'b1;
      else if (result_ready) result_valid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (lookup_fire) begin
         result_class <= lk_class;
         hit_way_vec <= true_hit_vec | upgrade_vec;
         current_state <= (true_hit || upgrade) ? hit_state : '0;
         busy_vec <= busy | start_vec;
         stale_vec <= (busy & ~despite_hit) | (start_vec & ~{N_WAYS{true_hit}});
         nack_no_allocate <= all_busy;
      end
   end

endmodule

`default_nettype wire

/* source/tag_state_array.sv */
// committed tags and states, shadow tags, fill-despite-hit flags, maintenance access
`default_nettype none
`timescale 1ns/100ps

module tag_state_array
   import cache_set_pkg::*;
   import cache_maint_pkg::*;
#(
   parameter int unsigned N_WAYS = 2,
   parameter int unsigned SET_INDEX = 0,
   parameter int unsigned BANK_INDEX = 0
) (
   input wire clk,
   input wire reset_n,
   input wire fill_start,
   input wire [WAY_W-1:0] start_way,
   input wire tagsec_t start_tag,
   input wire start_hit,
   input wire upd_valid,
   input wire [WAY_W-1:0] upd_way,
   input wire [STATE_W-1:0] upd_state,
   input wire fill_fire,
   input wire fill_cmd_t fill_cmd,
   input wire [N_WAYS-1:0] busy,
   input wire [N_WAYS-1:0] state_pending,
   input wire maint_fire,
   input wire maint_req_t maint_req,
   input wire maint_word_u maint_wdata,
   output tagsec_t [N_WAYS-1:0] tags,
   output logic [N_WAYS-1:0][STATE_W-1:0] states,
   output tagsec_t [N_WAYS-1:0] shadow_tags,
   output logic [N_WAYS-1:0] despite_hit,
   output maint_word_u maint_rdata,
   output logic maint_rvalid
);

   logic fill_here;
   logic maint_wr;
   logic maint_rd;
   tagsec_t fill_tag;
   maint_word_u rd_word;

   // a fill command only commits to a way still waiting for its state
   assign fill_here = fill_fire &&
                      (fill_cmd.addr.set == SET_W'(SET_INDEX)) &&
                      (fill_cmd.addr.bank == BANK_W'(BANK_INDEX)) &&
                      |((N_WAYS'(1) << fill_cmd.way) & state_pending);
   assign fill_tag = '{security: fill_cmd.security, tag: fill_cmd.addr.tag};

   // maintenance writes to word 0 of a way with no fill in flight
   assign maint_wr = maint_fire && (maint_req.op == op_write) && (maint_req.word == '0) &&
                     !(|((N_WAYS'(1) << maint_req.way) & busy));
   assign maint_rd = maint_fire && (maint_req.op == op_read);

   // later writes in the block take priority
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         tags <= '0;
         states <= '0;
         despite_hit <= '0;
      end else begin
         for (int i = 0; i < N_WAYS; i++) begin
            if (fill_start && (start_way == WAY_W'(i))) begin
               despite_hit[i] <= start_hit;
            end
            if (upd_valid && (upd_way == WAY_W'(i))) begin
               tags[i] <= start_tag;
               states[i] <= upd_state;
            end
            if (fill_here && (fill_cmd.way == WAY_W'(i))) begin
               tags[i] <= fill_tag;
               states[i] <= fill_cmd.state;
            end
            if (maint_wr && (maint_req.way == WAY_W'(i))) begin
               tags[i] <= maint_wdata.fields.tagsec;
               states[i] <= maint_wdata.fields.state;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < N_WAYS; i++) begin
         if (fill_start && (start_way == WAY_W'(i))) begin
            shadow_tags[i] <= start_tag;
         end
      end
   end

   // read word 0 only, nru and err read back as zero
   always_comb begin
      rd_word = '0;
      for (int i = 0; i < N_WAYS; i++) begin
         if ((maint_req.way == WAY_W'(i)) && (maint_req.word == '0)) begin
            rd_word.fields.tagsec = tags[i];
            rd_word.fields.state = states[i];
         end
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         maint_rvalid <= 1'b0;
      end else begin
         maint_rvalid <= maint_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (maint_rd) begin
         maint_rdata <= rd_word;
      end
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+test
source/cache_set_pkg.sv
source/cache_maint_pkg.sv
source/fill_tracker.sv
source/fill_beat_counter.sv
source/tag_state_array.sv
source/lookup_classifier.sv
source/cache_set_top.sv
test/tb_cache_set.sv

/* test/tb_vectors.svh */
// step table types and the stimulus and expected value table for the cache set testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum logic [2:0] {
   act_lookup,
   act_fill,
   act_burst,
   act_done,
   act_mwrite,
   act_mread
} action_e;

typedef struct packed {
   action_e act;
   logic [TAG_W-1:0] tag;
   logic sec;
   logic alloc;
   logic stall;
   logic [WAY_W-1:0] way;
   logic [STATE_W-1:0] state;
   logic [FILL_ID_W-1:0] id;
   logic [31:0] wdata;
} drive_t;

typedef struct packed {
   lookup_class_e cls;
   logic [N_WAYS-1:0] hit;
   logic [STATE_W-1:0] state;
   logic [N_WAYS-1:0] busy;
   logic [N_WAYS-1:0] stale;
   logic nack;
   logic [31:0] rdata;
} expect_t;

typedef struct packed {
   drive_t drv;
   expect_t exp;
} step_t;

localparam int N_STEPS = 14;

// drive: action, tag, security, allocate, stall, way, state, fill id, maintenance write word
// expect: class, hit ways, state, busy ways, stale ways, nack, maintenance read word
// word 0 layout from the top: 11 pad bits, security, tag, state, nru, err
localparam step_t STEPS [N_STEPS] = '{
   '{'{act_lookup, 16'h1234, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 6'h00, 32'h0},
     '{class_true_miss, 2'b00, 2'd0, 2'b01, 2'b01, 1'b0, 32'h0}},
   '{'{act_lookup, 16'h1234, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 6'h00, 32'h0},
     '{class_false_miss, 2'b00, 2'd0, 2'b01, 2'b01, 1'b0, 32'h0}},
   '{'{act_fill, 16'h1234, 1'b0, 1'b0, 1'b0, 2'd0, 2'd3, 6'h00, 32'h0},
     '{class_true_miss, 2'b00, 2'd0, 2'b00, 2'b00, 1'b0, 32'h0}},
   '{'{act_burst, 16'h0000, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, 6'h2a, 32'h0},
     '{class_true_miss, 2'b00, 2'd0, 2'b00, 2'b00, 1'b0, 32'h0}},
   // wrong id, way 0 stays done pending
   '{'{act_done, 16'h0000, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, 6'h15, 32'h0},
     '{class_true_miss, 2'b00, 2'd0, 2'b00, 2'b00, 1'b0, 32'h0}},
   '{'{act_lookup, 16'h1234, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, 6'h00, 32'h0},
     '{class_false_miss, 2'b00, 2'd0, 2'b01, 2'b01, 1'b0, 32'h0}},
   '{'{act_done, 16'h0000, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, 6'h2a, 32'h0},
     '{class_true_miss, 2'b00, 2'd0, 2'b00, 2'b00, 1'b0, 32'h0}},
   '{'{act_lookup, 16'h1234, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, 6'h00, 32'h0},
     '{class_true_hit, 2'b01, 2'd3, 2'b00, 2'b00, 1'b0, 32'h0}},
   // nru and err written as one, read back as zero
   '{'{act_mwrite, 16'h0000, 1'b0, 1'b0, 1'b0, 2'd1, 2'd0, 6'h00, 32'h0015_a5ab},
     '{class_true_miss, 2'b00, 2'd0, 2'b00, 2'b00, 1'b0, 32'h0}},
   '{'{act_mread, 16'h0000, 1'b0, 1'b0, 1'b0, 2'd1, 2'd0, 6'h00, 32'h0},
     '{class_true_miss, 2'b00, 2'd0, 2'b00, 2'b00, 1'b0, 32'h0015_a5a8}},
   '{'{act_lookup, 16'h5a5a, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0, 6'h00, 32'h0},
     '{class_true_hit, 2'b10, 2'd2, 2'b00, 2'b00, 1'b0, 32'h0}},
   '{'{act_lookup, 16'h0bee, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 6'h00, 32'h0},
     '{class_true_miss, 2'b00, 2'd0, 2'b01, 2'b01, 1'b0, 32'h0}},
   '{'{act_lookup, 16'h0c0d, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 6'h00, 32'h0},
     '{class_true_miss, 2'b00, 2'd0, 2'b11, 2'b11, 1'b0, 32'h0}},
   // every way busy, result held by a stalled consumer
   '{'{act_lookup, 16'h0d0e, 1'b0, 1'b1, 1'b1, 2'd0, 2'd0, 6'h00, 32'h0},
     '{class_true_miss, 2'b00, 2'd0, 2'b11, 2'b11, 1'b1, 32'h0}}
};

`endif

/* test/tb_cache_set.sv */
// cache set testbench with clock, reset, random beat data, step table loop and checks
`default_nettype none
`timescale 1ns/100ps

module tb_cache_set
   import cache_set_pkg::*;
   import cache_maint_pkg::*;
();

   localparam int unsigned N_WAYS = 2;
   localparam int unsigned BURST_BEATS = 4;
   localparam int unsigned SET_INDEX = 5;
   localparam int unsigned BANK_INDEX = 1;
   localparam int TIMEOUT = 50;

   `include "tb_vectors.svh"

   typedef enum int {
      w_lookup_ready,
      w_result_valid,
      w_fill_ready,
      w_beat_ready,
      w_maint_ready,
      w_maint_rvalid
   } wait_sel_e;

   logic clk;
   logic reset_n;
   logic lookup_valid;
   logic lookup_ready;
   lookup_req_t lookup_req;
   logic result_valid;
   logic result_ready;
   lookup_class_e result_class;
   logic [N_WAYS-1:0] hit_way_vec;
   logic [STATE_W-1:0] current_state;
   logic [N_WAYS-1:0] busy_vec;
   logic [N_WAYS-1:0] stale_vec;
   logic nack_no_allocate;
   logic fill_valid;
   logic fill_ready;
   fill_cmd_t fill_cmd;
   logic beat_valid;
   logic beat_ready;
   fill_beat_t fill_beat;
   logic done_valid;
   logic [FILL_ID_W-1:0] done_id;
   logic maint_valid;
   logic maint_ready;
   maint_req_t maint_req;
   maint_word_u maint_wdata;
   maint_word_u maint_rdata;
   logic maint_rvalid;
   logic [31:0] lcg_state;

   cache_set_top #(
      .N_WAYS(N_WAYS), .BURST_BEATS(BURST_BEATS),
      .SET_INDEX(SET_INDEX), .BANK_INDEX(BANK_INDEX)
   ) i_dut (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         fail_now($sformatf("mismatch: time %0t, %s got %0h expected %0h",
                            $time, name, got, exp));
      end
   endtask

   function automatic logic signal_of(input wait_sel_e sel);
      case (sel)
         w_lookup_ready: return lookup_ready;
         w_result_valid: return result_valid;
         w_fill_ready: return fill_ready;
         w_beat_ready: return beat_ready;
         w_maint_ready: return maint_ready;
         default: return maint_rvalid;
      endcase
   endfunction

   // polls just after each rising edge until the signal is high
   task automatic wait_for(input wait_sel_e sel, input string what);
      int n;
      n = 0;
      while (!signal_of(sel)) begin
         if (n == TIMEOUT) fail_now({"timeout while waiting for ", what});
         @(posedge clk);
         #1;
         n++;
      end
   endtask

   task automatic check_result(input expect_t e);
      check_value("result_class", 32'(result_class), 32'(e.cls));
      check_value("hit_way_vec", 32'(hit_way_vec), 32'(e.hit));
      check_value("current_state", 32'(current_state), 32'(e.state));
      check_value("busy_vec", 32'(busy_vec), 32'(e.busy));
      check_value("stale_vec", 32'(stale_vec), 32'(e.stale));
      check_value("nack_no_allocate", 32'(nack_no_allocate), 32'(e.nack));
   endtask

   // result must hold while a lookup to another set waits on a stalled consumer
   task automatic hold_result(input expect_t e);
      lookup_req_t other;
      other = lookup_req;
      other.addr.set = SET_W'(SET_INDEX + 1);
      result_ready = 1'b0;
      lookup_req = other;
      lookup_valid = 1'b1;
      repeat (3) begin
         @(posedge clk);
         #1;
         check_value("result_valid", 32'(result_valid), 32'd1);
         check_value("lookup_ready", 32'(lookup_ready), 32'd0);
         check_result(e);
      end
      lookup_valid = 1'b0;
      result_ready = 1'b1;
      @(posedge clk);
      #1;
      check_value("result_valid", 32'(result_valid), 32'd0);
   endtask

   task automatic issue_lookup(input step_t s);
      lookup_req_t req;
      req = '0;
      req.addr.tag = s.drv.tag;
      req.addr.bank = BANK_W'(BANK_INDEX);
      req.addr.set = SET_W'(SET_INDEX);
      req.security = s.drv.sec;
      req.allocate = s.drv.alloc;
      lookup_req = req;
      lookup_valid = 1'b1;
      wait_for(w_lookup_ready, "lookup_ready");
      @(posedge clk);
      #1;
      lookup_valid = 1'b0;
      wait_for(w_result_valid, "result_valid");
      check_result(s.exp);
      if (s.drv.stall) hold_result(s.exp);
   endtask

   task automatic send_fill_cmd(input drive_t d);
      fill_cmd_t cmd;
      cmd = '0;
      cmd.addr.tag = d.tag;
      cmd.addr.bank = BANK_W'(BANK_INDEX);
      cmd.addr.set = SET_W'(SET_INDEX);
      cmd.security = d.sec;
      cmd.way = d.way;
      cmd.state = d.state;
      fill_cmd = cmd;
      fill_valid = 1'b1;
      wait_for(w_fill_ready, "fill_ready");
      @(posedge clk);
      #1;
      fill_valid = 1'b0;
   endtask

   task automatic stream_burst(input drive_t d);
      fill_beat_t beat;
      for (int b = 0; b < BURST_BEATS; b++) begin
         beat.data[63:32] = next_random();
         beat.data[31:0] = next_random();
         beat.way = d.way;
         beat.id = d.id;
         fill_beat = beat;
         beat_valid = 1'b1;
         wait_for(w_beat_ready, "beat_ready");
         @(posedge clk);
         #1;
      end
      beat_valid = 1'b0;
   endtask

   task automatic pulse_done(input drive_t d);
      done_id = d.id;
      done_valid = 1'b1;
      @(posedge clk);
      #1;
      done_valid = 1'b0;
   endtask

   task automatic run_maint(input step_t s);
      maint_req_t req;
      req.op = (s.drv.act == act_mread) ? op_read : op_write;
      req.way = s.drv.way;
      req.word = '0;
      maint_req = req;
      maint_wdata.raw = s.drv.wdata;
      maint_valid = 1'b1;
      wait_for(w_maint_ready, "maint_ready");
      @(posedge clk);
      #1;
      maint_valid = 1'b0;
      if (s.drv.act == act_mread) begin
         wait_for(w_maint_rvalid, "maint_rvalid");
         check_value("maint_rdata", maint_rdata.raw, s.exp.rdata);
      end
   endtask

   initial begin
      lcg_state = 32'ha205_39d7;
      reset_n = 1'b0;
      lookup_valid = 1'b0;
      lookup_req = '0;
      result_ready = 1'b1;
      fill_valid = 1'b0;
      fill_cmd = '0;
      beat_valid = 1'b0;
      fill_beat = '0;
      done_valid = 1'b0;
      done_id = '0;
      maint_valid = 1'b0;
      maint_req = '0;
      maint_wdata = '0;
      repeat (4) @(posedge clk);
      #1;
      reset_n = 1'b1;
      @(posedge clk);
      #1;
      check_value("result_valid", 32'(result_valid), 32'd0);
      check_value("maint_rvalid", 32'(maint_rvalid), 32'd0);
      for (int i = 0; i < N_STEPS; i++) begin
         case (STEPS[i].drv.act)
            act_lookup: issue_lookup(STEPS[i]);
            act_fill: send_fill_cmd(STEPS[i].drv);
            act_burst: stream_burst(STEPS[i].drv);
            act_done: pulse_done(STEPS[i].drv);
            default: run_maint(STEPS[i]);
         endcase
      end
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire
